/* Makefile */
# Verilator build and run for the AHB to APB bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_apb_bridge
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
logic/bridge_pkg.sv
logic/ahb_addr_capture.sv
logic/apb_fsm.sv
logic/apb_wait_timer.sv
logic/ahb_resp_gen.sv
logic/ahb_apb_bridge.sv
tb/apb_slave_model.sv
tb/tb_ahb_apb_bridge.sv

/* logic/ahb_addr_capture.sv */
// AHB address phase capture: window decode and holding of APB transfer attributes
`timescale 1ns/10ps

module ahb_addr_capture import bridge_pkg::*; #(
    parameter addr_t WINDOW_BASE  = 32'h0020_0000,
    parameter addr_t WINDOW_LIMIT = 32'h0100_0000
) (
    input  logic       ahb_clk,
    input  logic       ahb_resetn,
    input  addr_t      haddr,
    input  logic [1:0] htrans,
    input  logic       hwrite,
    input  data_t      hwdata,
    input  logic       hready,
    input  logic       take_wdata,
    output logic       hit,
    output logic       miss,
    output addr_t      paddr,
    output logic       pwrite,
    output data_t      pwdata
);

    logic addr_phase;
    logic in_window;

    // NONSEQ or SEQ sampled while the bus is ready
    assign addr_phase = hready && htrans[1];

    // Window is half-open, LIMIT itself is outside
    assign in_window = (haddr >= WINDOW_BASE) && (haddr < WINDOW_LIMIT);

    // Hit is seen by the FSM and response block at the sampling edge itself
    assign hit = addr_phase && in_window;

    // Miss marks the data phase of an out-of-window transfer
    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            miss <= 1'b0;
        end else begin
            miss <= addr_phase && !in_window;
        end
    end

    // Address and direction stay put for the whole APB transfer
    always_ff @(posedge ahb_clk) begin
        if (hit) begin
            paddr  <= haddr;
            pwrite <= hwrite;
        end
    end

    // HWDATA arrives one cycle after the address
    always_ff @(posedge ahb_clk) begin
        if (take_wdata) begin
            pwdata <= hwdata;
        end
    end

endmodule

/* logic/ahb_apb_bridge.sv */
// AHB-Lite to APB bridge top: address window decode, APB sequencing and AHB response
`timescale 1ns/10ps

module ahb_apb_bridge import bridge_pkg::*; #(
    parameter addr_t WINDOW_BASE  = 32'h0020_0000,
    parameter addr_t WINDOW_LIMIT = 32'h0100_0000,
    parameter int    MAX_WAIT     = 16
) (
    // AHB slave side
    input  logic       ahb_clk,
    input  logic       ahb_resetn,
    input  addr_t      haddr,
    input  logic [1:0] htrans,
    input  logic       hwrite,
    input  data_t      hwdata,
    output data_t      hrdata,
    output logic       hready,
    output logic       hresp,

    // APB master side
    output addr_t      paddr,
    output logic       pwrite,
    output logic       psel,
    output logic       penable,
    output data_t      pwdata,
    input  data_t      prdata,
    input  logic       pready,
    input  logic       pslverr
);

    logic          hit;
    logic          miss;
    logic          take_wdata;
    logic          in_access;
    logic          done_ok;
    logic          done_err;
    logic          timeout;
    // Current bridge state, probed by the testbench
    bridge_state_t fsm_state;

    ahb_addr_capture #(
        .WINDOW_BASE  (WINDOW_BASE),
        .WINDOW_LIMIT (WINDOW_LIMIT)
    ) u_addr_capture (
        .ahb_clk    (ahb_clk),
        .ahb_resetn (ahb_resetn),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hready     (hready),
        .take_wdata (take_wdata),
        .hit        (hit),
        .miss       (miss),
        .paddr      (paddr),
        .pwrite     (pwrite),
        .pwdata     (pwdata)
    );

    apb_fsm u_fsm (
        .ahb_clk    (ahb_clk),
        .ahb_resetn (ahb_resetn),
        .hit        (hit),
        .pready     (pready),
        .pslverr    (pslverr),
        .timeout    (timeout),
        .psel       (psel),
        .penable    (penable),
        .take_wdata (take_wdata),
        .in_access  (in_access),
        .done_ok    (done_ok),
        .done_err   (done_err),
        .state      (fsm_state)
    );

    apb_wait_timer #(
        .MAX_WAIT (MAX_WAIT)
    ) u_wait_timer (
        .ahb_clk    (ahb_clk),
        .ahb_resetn (ahb_resetn),
        .in_access  (in_access),
        .pready     (pready),
        .timeout    (timeout)
    );

    ahb_resp_gen u_resp_gen (
        .ahb_clk    (ahb_clk),
        .ahb_resetn (ahb_resetn),
        .hit        (hit),
        .miss       (miss),
        .done_ok    (done_ok),
        .done_err   (done_err),
        .prdata     (prdata),
        .pwrite     (pwrite),
        .hready     (hready),
        .hresp      (hresp),
        .hrdata     (hrdata)
    );

endmodule

/* logic/ahb_resp_gen.sv */
// AHB response generator: HREADY, HRESP and HRDATA for bridged transfers
`timescale 1ns/10ps

module ahb_resp_gen import bridge_pkg::*; (
    input  logic  ahb_clk,
    input  logic  ahb_resetn,
    input  logic  hit,
    input  logic  miss,
    input  logic  done_ok,
    input  logic  done_err,
    input  data_t prdata,
    input  logic  pwrite,
    output logic  hready,
    output logic  hresp,
    output data_t hrdata
);

    logic hready_q;
    logic hresp_q;
    logic err_pending;

    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            hready_q    <= 1'b1;
            hresp_q     <= 1'b0;
            err_pending <= 1'b0;
        end else if (hit) begin
            // Stall the data phase until the APB side finishes
            hready_q <= 1'b0;
            hresp_q  <= 1'b0;
        end else if (done_ok) begin
            hready_q <= 1'b1;
            hresp_q  <= 1'b0;
        end else if (done_err) begin
            // First error cycle, HREADY still low
            hready_q    <= 1'b0;
            hresp_q     <= 1'b1;
            err_pending <= 1'b1;
        end else if (err_pending) begin
            hready_q    <= 1'b1;
            err_pending <= 1'b0;
        end else if (hready_q && hresp_q) begin
            // Second error cycle is over
            hresp_q <= 1'b0;
        end
    end

    // Out-of-window data phase is always a zero-wait OKAY
    assign hready = hready_q || miss;
    assign hresp  = hresp_q && !miss;

    // Read data only from reads that end OKAY, else last value is kept
    always_ff @(posedge ahb_clk) begin
        if (done_ok && !pwrite) begin
            hrdata <= prdata;
        end
    end

endmodule

/* logic/apb_fsm.sv */
// APB sequencer: walks capture, setup and access phases and flags completion
`timescale 1ns/10ps

module apb_fsm import bridge_pkg::*; (
    input  logic          ahb_clk,
    input  logic          ahb_resetn,
    input  logic          hit,
    input  logic          pready,
    input  logic          pslverr,
    input  logic          timeout,
    output logic          psel,
    output logic          penable,
    output logic          take_wdata,
    output logic          in_access,
    output logic          done_ok,
    output logic          done_err,
    output bridge_state_t state
);

    bridge_state_t next_state;
    logic          err_q;

    // Strobes decoded straight from the state register
    assign psel       = (state == SETUP) || (state == ACCESS);
    assign penable    = (state == ACCESS);
    assign take_wdata = (state == CAPTURE);
    assign in_access  = (state == ACCESS);

    // Completion, exactly one of these in the last access cycle
    assign done_ok  = in_access && pready && !pslverr;
    assign done_err = in_access && ((pready && pslverr) || timeout);

    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Remembers whether RESP has to be followed by ERR2
    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            err_q <= 1'b0;
        end else if (done_ok || done_err) begin
            err_q <= done_err;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (hit) begin
                    next_state = CAPTURE;
                end
            end
            CAPTURE: begin
                next_state = SETUP;
            end
            SETUP: begin
                next_state = ACCESS;
            end
            ACCESS: begin
                // Timeout leaves without a completed APB transfer
                if (done_ok || done_err) begin
                    next_state = RESP;
                end
            end
            RESP: begin
                // HREADY is high here on OKAY, so a new address may already be in
                if (err_q) begin
                    next_state = ERR2;
                end else if (hit) begin
                    next_state = CAPTURE;
                end else begin
                    next_state = IDLE;
                end
            end
            ERR2: begin
                if (hit) begin
                    next_state = CAPTURE;
                end else begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* logic/apb_wait_timer.sv */
// APB wait timer: counts stalled access cycles and flags a timeout
`timescale 1ns/10ps

module apb_wait_timer import bridge_pkg::*; #(
    parameter int MAX_WAIT = 16
) (
    input  logic ahb_clk,
    input  logic ahb_resetn,
    input  logic in_access,
    input  logic pready,
    output logic timeout
);

    wait_cnt_t stall_cnt;
    logic      stalled;

    assign stalled = in_access && !pready;

    // Saturating count, cleared whenever the FSM is outside ACCESS
    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            stall_cnt <= '0;
        end else if (!in_access) begin
            stall_cnt <= '0;
        end else if (stalled && (stall_cnt != wait_cnt_t'(MAX_WAIT))) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // Fires in the stalled cycle that brings the count to MAX_WAIT,
    // so ACCESS ends on that same edge
    assign timeout = stalled && (stall_cnt >= wait_cnt_t'(MAX_WAIT - 1));

endmodule

/* logic/bridge_pkg.sv */
// AHB to APB bridge shared types: bus widths, wait counter and bridge states
package bridge_pkg;

    // 32-bit AHB/APB byte address
    typedef logic [31:0] addr_t;

    // One full bus word, the only transfer size supported
    typedef logic [31:0] data_t;

    // Access-phase stall counter
    typedef logic [7:0] wait_cnt_t;

    // Bridge sequencing states
    typedef enum logic [2:0] {
        // Waiting for an in-window address phase
        IDLE    = 3'd0,
        // AHB data phase, HWDATA is valid here
        CAPTURE = 3'd1,
        // APB setup, PSEL high and PENABLE low
        SETUP   = 3'd2,
        // APB access, held while PREADY is low
        ACCESS  = 3'd3,
        // OKAY response, or first cycle of an ERROR
        RESP    = 3'd4,
        // Second cycle of an ERROR response
        ERR2    = 3'd5
    } bridge_state_t;

endpackage

/* tb/apb_slave_model.sv */
// APB slave model: small register memory with programmable wait states, an error and a hang address
`timescale 1ns/10ps

module apb_slave_model import bridge_pkg::*; #(
    parameter addr_t ERR_ADDR  = 32'h0020_0F00,
    parameter addr_t HANG_ADDR = 32'h0020_0F04
) (
    input  logic       ahb_clk,
    input  logic       ahb_resetn,
    input  addr_t      paddr,
    input  logic       pwrite,
    input  logic       psel,
    input  logic       penable,
    input  data_t      pwdata,
    input  logic [1:0] wait_states,
    output data_t      prdata,
    output logic       pready,
    output logic       pslverr
);

    // 16 words, indexed by the word address bits
    data_t      regs [16];
    logic [1:0] wait_cnt;
    logic       access;

    assign access = psel && penable;

    // Hang address keeps PREADY low forever
    assign pready  = access && (wait_cnt == wait_states) && (paddr != HANG_ADDR);
    assign pslverr = pready && (paddr == ERR_ADDR);
    assign prdata  = regs[paddr[5:2]];

    // Wait states counted from the first access cycle
    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            wait_cnt <= '0;
        end else if (!access || pready) begin
            wait_cnt <= '0;
        end else if (wait_cnt != wait_states) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Rejected writes leave the memory alone
    always_ff @(posedge ahb_clk) begin
        if (pready && pwrite && !pslverr) begin
            regs[paddr[5:2]] <= pwdata;
        end
    end

endmodule

/* tb/tb_ahb_apb_bridge.sv */
// Testbench for the AHB to APB bridge: pipelined AHB master, APB slave model and protocol checks
`timescale 1ns/10ps

module tb_ahb_apb_bridge import bridge_pkg::*; ();

    localparam addr_t WINDOW_BASE  = 32'h0020_0000;
    localparam addr_t WINDOW_LIMIT = 32'h0100_0000;
    localparam int    MAX_WAIT     = 16;
    localparam addr_t DATA_BASE    = 32'h0020_0100;
    localparam addr_t ERR_ADDR     = 32'h0020_0F00;
    localparam addr_t HANG_ADDR    = 32'h0020_0F04;
    // Cycles allowed between two completed data phases
    localparam int    XFER_GUARD   = 64;

    typedef struct packed {
        addr_t      addr;
        logic       write;
        data_t      wdata;
        logic [1:0] trans;
        logic [1:0] waits;
    } xfer_t;

    logic       ahb_clk;
    logic       ahb_resetn;
    addr_t      haddr;
    logic [1:0] htrans;
    logic       hwrite;
    data_t      hwdata;
    data_t      hrdata;
    logic       hready;
    logic       hresp;
    addr_t      paddr;
    logic       pwrite;
    logic       psel;
    logic       penable;
    data_t      pwdata;
    data_t      prdata;
    logic       pready;
    logic       pslverr;
    logic [1:0] slave_waits;

    // What the APB side should show for the transfer in its data phase
    addr_t      exp_paddr;
    logic       exp_pwrite;
    data_t      exp_pwdata;
    logic       exp_apb;
    int         stall_run;

    xfer_t      xq[$];
    data_t      ref_mem [addr_t];

    ahb_apb_bridge #(
        .WINDOW_BASE  (WINDOW_BASE),
        .WINDOW_LIMIT (WINDOW_LIMIT),
        .MAX_WAIT     (MAX_WAIT)
    ) UUT (
        .ahb_clk    (ahb_clk),
        .ahb_resetn (ahb_resetn),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hrdata     (hrdata),
        .hready     (hready),
        .hresp      (hresp),
        .paddr      (paddr),
        .pwrite     (pwrite),
        .psel       (psel),
        .penable    (penable),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    apb_slave_model #(
        .ERR_ADDR  (ERR_ADDR),
        .HANG_ADDR (HANG_ADDR)
    ) slave (
        .ahb_clk     (ahb_clk),
        .ahb_resetn  (ahb_resetn),
        .paddr       (paddr),
        .pwrite      (pwrite),
        .psel        (psel),
        .penable     (penable),
        .pwdata      (pwdata),
        .wait_states (slave_waits),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    initial begin
        ahb_clk = 1'b0;
        forever #4 ahb_clk = ~ahb_clk;
    end

    task automatic fail_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", XFER_GUARD, what);
        $display("TEST FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    // Stalled access cycles seen so far in the current APB access
    always_ff @(posedge ahb_clk or negedge ahb_resetn) begin
        if (!ahb_resetn) begin
            stall_run <= 0;
        end else if (psel && penable && !pready) begin
            stall_run <= stall_run + 1;
        end else begin
            stall_run <= 0;
        end
    end

    a_setup_first: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        $rose(psel) |-> !penable)
        else fail_mismatch("APB transfer started without a setup phase");

    a_setup_then_access: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        psel && !penable |=> psel && penable)
        else fail_mismatch("APB setup phase not followed by an access phase");

    a_wait_holds: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        psel && penable && !pready && (stall_run < MAX_WAIT - 1)
        |=> psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else fail_mismatch("APB access not held stable during wait states");

    a_timeout_drop: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        psel && penable && !pready && (stall_run == MAX_WAIT - 1) |=> !psel)
        else fail_mismatch("PSEL still high after the last allowed wait cycle");

    a_apb_attrs: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        psel |-> exp_apb && (paddr == exp_paddr) && (pwrite == exp_pwrite))
        else fail_mismatch("unexpected APB select, address or direction");

    a_apb_wdata: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        psel && pwrite |-> pwdata == exp_pwdata)
        else fail_mismatch("PWDATA differs from the AHB write data");

    a_err_first: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        hresp && !hready |=> hresp && hready)
        else fail_mismatch("first ERROR cycle not followed by the second");

    a_err_second: assert property (@(posedge ahb_clk) disable iff (!ahb_resetn)
        hresp && hready |-> $past(hresp && !hready))
        else fail_mismatch("ERROR completion without the HREADY-low cycle");

    function automatic logic goes_to_apb(input xfer_t x);
        return x.trans[1] && (x.addr >= WINDOW_BASE) && (x.addr < WINDOW_LIMIT);
    endfunction

    function automatic logic expects_error(input xfer_t x);
        return goes_to_apb(x) && ((x.addr == ERR_ADDR) || (x.addr == HANG_ADDR));
    endfunction

    // Capture, setup, access and one or two response cycles
    function automatic int expected_cycles(input xfer_t x);
        if (!goes_to_apb(x)) begin
            return 1;
        end else if (x.addr == HANG_ADDR) begin
            return 2 + MAX_WAIT + 2;
        end else if (x.addr == ERR_ADDR) begin
            return 3 + int'(x.waits) + 2;
        end
        return 3 + int'(x.waits) + 1;
    endfunction

    function automatic void add_xfer(input addr_t addr, input logic write, input data_t wdata,
                                     input logic [1:0] trans, input logic [1:0] waits);
        xfer_t x;
        x.addr  = addr;
        x.write = write;
        x.wdata = wdata;
        x.trans = trans;
        x.waits = waits;
        xq.push_back(x);
    endfunction

    task automatic check_completion(input xfer_t x, input int cycles, input logic prev_hresp);
        logic err;
        err = expects_error(x);
        assert (cycles == expected_cycles(x)) else fail_mismatch($sformatf(
            "data phase at %h took %0d cycles, expected %0d", x.addr, cycles, expected_cycles(x)));
        assert (hresp === err) else fail_mismatch($sformatf(
            "HRESP %b at %h, expected %b", hresp, x.addr, err));
        if (err) begin
            assert (prev_hresp) else fail_mismatch("ERROR without its HREADY-low first cycle");
        end else if (goes_to_apb(x) && x.write) begin
            ref_mem[x.addr] = x.wdata;
        end else if (goes_to_apb(x) && ref_mem.exists(x.addr)) begin
            assert (hrdata === ref_mem[x.addr]) else fail_mismatch($sformatf(
                "HRDATA %h at %h, expected %h", hrdata, x.addr, ref_mem[x.addr]));
        end
    endtask

    // Pipelined master that puts out a new address only in a cycle with HREADY high
    task automatic run_queue();
        xfer_t ap;
        xfer_t dp;
        logic  ap_valid;
        logic  dp_valid;
        logic  rdy;
        logic  last_hresp;
        int    cycles;
        int    guard;
        ap_valid   = 1'b0;
        dp_valid   = 1'b0;
        last_hresp = 1'b0;
        cycles     = 0;
        guard      = 0;
        while ((xq.size() > 0) || ap_valid || dp_valid) begin
            @(negedge ahb_clk);
            guard++;
            if (guard > XFER_GUARD) begin
                fail_timeout("HREADY to end a data phase");
            end
            rdy = hready;
            if (ap_valid) begin
                dp          = ap;
                dp_valid    = 1'b1;
                ap_valid    = 1'b0;
                cycles      = 0;
                last_hresp  = 1'b0;
                hwdata      = ap.wdata;
                slave_waits = ap.waits;
                exp_paddr   = ap.addr;
                exp_pwrite  = ap.write;
                exp_pwdata  = ap.wdata;
                exp_apb     = goes_to_apb(ap);
            end
            if (dp_valid) begin
                cycles++;
                if (rdy) begin
                    check_completion(dp, cycles, last_hresp);
                    dp_valid = 1'b0;
                    guard    = 0;
                end
                last_hresp = hresp;
            end
            if (rdy && (xq.size() > 0)) begin
                ap       = xq.pop_front();
                haddr    = ap.addr;
                htrans   = ap.trans;
                hwrite   = ap.write;
                ap_valid = 1'b1;
            end else begin
                htrans = 2'b00;
            end
        end
    endtask

    initial begin
        addr_t       written[$];
        addr_t       a;
        int unsigned idx;
        void'($urandom(32'hcd51));
        ahb_resetn  = 1'b0;
        haddr       = '0;
        htrans      = 2'b00;
        hwrite      = 1'b0;
        hwdata      = '0;
        slave_waits = 2'd0;
        exp_paddr   = '0;
        exp_pwrite  = 1'b0;
        exp_pwdata  = '0;
        exp_apb     = 1'b0;
        repeat (4) @(posedge ahb_clk);
        @(negedge ahb_clk);
        ahb_resetn = 1'b1;
        assert ((hready === 1'b1) && (hresp === 1'b0) && (psel === 1'b0) && (penable === 1'b0)
                && (UUT.fsm_state === IDLE))
            else fail_mismatch("bus outputs or bridge state not at their reset values");

        // Random writes with random waits, then read back in reverse order
        repeat (10) begin
            idx = $urandom_range(15);
            a   = DATA_BASE + (addr_t'(idx) << 2);
            written.push_back(a);
            add_xfer(a, 1'b1, $urandom, 2'b10, 2'($urandom_range(3)));
        end
        for (int i = written.size() - 1; i >= 0; i--) begin
            add_xfer(written[i], 1'b0, '0, (i % 2 == 0) ? 2'b10 : 2'b11,
                     2'($urandom_range(3)));
        end
        run_queue();

        // Back-to-back transfers with zero wait states
        for (int i = 0; i < 4; i++) begin
            add_xfer(DATA_BASE + (addr_t'(i) << 2), 1'b1, $urandom, 2'b10, 2'd0);
        end
        for (int i = 0; i < 4; i++) begin
            add_xfer(DATA_BASE + (addr_t'(i) << 2), 1'b0, '0, 2'b10, 2'd0);
        end
        run_queue();

        // Outside the window, and an IDLE write that must not reach the slave
        add_xfer(WINDOW_BASE - 32'd4, 1'b1, $urandom, 2'b10, 2'd0);
        add_xfer(WINDOW_LIMIT, 1'b0, '0, 2'b10, 2'd0);
        add_xfer(DATA_BASE, 1'b1, $urandom, 2'b00, 2'd0);
        add_xfer(DATA_BASE, 1'b0, '0, 2'b10, 2'd0);

        // Slave error, then a hung access and a normal one after it
        add_xfer(ERR_ADDR, 1'b1, $urandom, 2'b10, 2'($urandom_range(3)));
        add_xfer(ERR_ADDR, 1'b0, '0, 2'b10, 2'($urandom_range(3)));
        add_xfer(HANG_ADDR, 1'b0, '0, 2'b10, 2'd0);
        add_xfer(DATA_BASE + 32'd4, 1'b0, '0, 2'b10, 2'd1);
        run_queue();

        $display("TEST PASS");
        $finish;
    end

endmodule
